// File: list.f
logic/csr_arch_pkg.sv
logic/csr_pipe_pkg.sv
logic/csr_decode.sv
logic/csr_timer.sv
logic/csr_regfile.sv
logic/csr_unit.sv
sim/csr_unit_assert.sv
sim/tb_csr_unit.sv

// File: logic/csr_arch_pkg.sv
`default_nettype none

package csr_arch_pkg;

    localparam int timer_w = 32;
    localparam int irq_w = 13;      // 2 sw, 8 hw, reserved, timer, ipi
    localparam int eentry_align = 6;

    typedef logic [13:0] csr_num_t;

    localparam csr_num_t csr_crmd   = 14'h000;
    localparam csr_num_t csr_prmd   = 14'h001;
    localparam csr_num_t csr_ecfg   = 14'h004;
    localparam csr_num_t csr_estat  = 14'h005;
    localparam csr_num_t csr_era    = 14'h006;
    localparam csr_num_t csr_badv   = 14'h007;
    localparam csr_num_t csr_eentry = 14'h00c;
    localparam csr_num_t csr_save0  = 14'h030;
    localparam csr_num_t csr_save1  = 14'h031;
    localparam csr_num_t csr_save2  = 14'h032;
    localparam csr_num_t csr_save3  = 14'h033;
    localparam csr_num_t csr_tid    = 14'h040;
    localparam csr_num_t csr_tcfg   = 14'h041;
    localparam csr_num_t csr_tval   = 14'h042;
    localparam csr_num_t csr_ticlr  = 14'h044;

    // exception codes as ESTAT.ecode holds them
    typedef enum logic [5:0] {
        ecode_int = 6'h00,
        ecode_ade = 6'h08,
        ecode_ale = 6'h09,
        ecode_sys = 6'h0b,
        ecode_brk = 6'h0c,
        ecode_ine = 6'h0d,
        ecode_ipe = 6'h0e
    } ecode_e;

    typedef struct packed {
        logic [1:0] datm;
        logic [1:0] datf;
        logic       pg;
        logic       da;
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    typedef struct packed {
        logic       pie;
        logic [1:0] pplv;
    } prmd_t;

    // da set, everything else clear
    localparam crmd_t crmd_rst = 9'h008;

    // ECFG.lie bit 10 is reserved
    localparam logic [irq_w-1:0] lie_mask = 13'h1bff;

endpackage

`default_nettype wire

// File: logic/csr_decode.sv
`default_nettype none

module csr_decode (
    input  wire logic                               clk,
    input  wire logic                               rstn,
    input  wire logic                               stall,
    input  wire logic                               flush,
    input  wire csr_pipe_pkg::csr_req_t             req,
    input  wire logic                               ti,
    input  wire logic [8:0]                         hw_int,
    input  wire csr_arch_pkg::crmd_t                crmd,
    input  wire logic [csr_arch_pkg::irq_w-1:0]     lie,
    input  wire logic [1:0]                         is_bits,
    input  wire logic [31:0]                        era,
    input  wire logic [31:0]                        eentry,
    input  wire logic [31:0]                        rdata_comb,
    output csr_arch_pkg::csr_num_t                  num_rd,
    output csr_pipe_pkg::csr_cmd_t                  cmd,
    output csr_pipe_pkg::csr_resp_t                 resp
);

    logic [csr_arch_pkg::irq_w-1:0] irq_src;
    logic                           int_pend;
    csr_pipe_pkg::csr_op_e          op_d;
    csr_arch_pkg::ecode_e           ecode_d;
    logic [8:0]                     esubcode_d;
    logic [31:0]                    wmask;
    csr_pipe_pkg::csr_cmd_t         cmd_d;
    csr_pipe_pkg::csr_resp_t        resp_d;

    assign num_rd = req.num;    // old value comes back from regfile

    // same layout as ESTAT.is
    assign irq_src = {hw_int[8], ti, 1'b0, hw_int[7:0], is_bits};
    assign int_pend = (|(irq_src & lie)) && crmd.ie;

    // exception > interrupt > own op
    always_comb
    begin
        op_d = req.op;
        ecode_d = req.ecode;
        esubcode_d = req.esubcode;
        if (req.excp)
        begin
            op_d = csr_pipe_pkg::op_trap;
        end
        else if (int_pend)
        begin
            op_d = csr_pipe_pkg::op_trap;
            ecode_d = csr_arch_pkg::ecode_int;
            esubcode_d = '0;
        end
    end

    assign wmask = (op_d == csr_pipe_pkg::op_csrxchg) ? req.mask : '1;

    always_comb
    begin
        cmd_d.run = req.valid && (op_d != csr_pipe_pkg::op_none);
        cmd_d.op = op_d;
        cmd_d.num = req.num;
        cmd_d.wdata = (rdata_comb & ~wmask) | (req.wdata & wmask);
        cmd_d.pc = req.pc;
        cmd_d.ecode = ecode_d;
        cmd_d.esubcode = esubcode_d;
        cmd_d.badv = req.badv;

        resp_d.rdata = rdata_comb;
        resp_d.flush = cmd_d.run && (op_d != csr_pipe_pkg::op_csrrd);
        case (op_d)
            csr_pipe_pkg::op_trap:
                resp_d.redirect_pc = eentry;
            csr_pipe_pkg::op_ertn:
                resp_d.redirect_pc = era;
            default:
                resp_d.redirect_pc = req.pc + 32'd4;
        endcase
    end

    // result stage
    always_ff @(posedge clk)
    begin
        if (!rstn || (flush && !stall))
        begin
            cmd <= '0;
            resp <= '0;
        end
        else if (!stall)
        begin
            cmd <= cmd_d;
            resp <= resp_d;
        end
    end

endmodule

`default_nettype wire

// File: logic/csr_pipe_pkg.sv
`default_nettype none

package csr_pipe_pkg;

    typedef enum logic [2:0] {
        op_none,
        op_csrrd,
        op_csrwr,
        op_csrxchg,
        op_ertn,
        op_trap
    } csr_op_e;

    // one privileged request from the pipeline
    typedef struct packed {
        logic                  valid;
        csr_op_e               op;
        csr_arch_pkg::csr_num_t num;
        logic [31:0]           wdata;
        logic [31:0]           mask;     // csrxchg only
        logic [31:0]           pc;
        logic                  excp;
        csr_arch_pkg::ecode_e  ecode;
        logic [8:0]            esubcode;
        logic [31:0]           badv;
    } csr_req_t;

    typedef struct packed {
        logic        flush;
        logic [31:0] redirect_pc;
        logic [31:0] rdata;
    } csr_resp_t;

    // registered command, op already arbitrated
    typedef struct packed {
        logic                  run;
        csr_op_e               op;
        csr_arch_pkg::csr_num_t num;
        logic [31:0]           wdata;    // merged under mask
        logic [31:0]           pc;
        csr_arch_pkg::ecode_e  ecode;
        logic [8:0]            esubcode;
        logic [31:0]           badv;
    } csr_cmd_t;

endpackage

`default_nettype wire

// File: logic/csr_regfile.sv
`default_nettype none

module csr_regfile (
    input  wire logic                               clk,
    input  wire logic                               rstn,
    input  wire logic                               stall,
    input  wire csr_pipe_pkg::csr_cmd_t             cmd,
    input  wire csr_arch_pkg::csr_num_t             num_rd,
    input  wire logic                               ti,
    input  wire logic [8:0]                         hw_int,
    input  wire logic [csr_arch_pkg::timer_w-1:0]   tval,
    output logic [31:0]                             rdata_comb,
    output csr_arch_pkg::crmd_t                     crmd,
    output logic [csr_arch_pkg::irq_w-1:0]          lie,
    output logic [1:0]                              is_bits,
    output logic [31:0]                             era,
    output logic [31:0]                             eentry,
    output logic                                    tcfg_wr,
    output logic [csr_arch_pkg::timer_w-1:0]        tcfg,
    output logic                                    ticlr_wr,
    output logic                                    excp_flush,
    output logic                                    ertn_flush
);

    csr_arch_pkg::prmd_t                       prmd;
    csr_arch_pkg::ecode_e                      ecode_q;
    logic [8:0]                                esubcode_q;
    logic [31:0]                               badv;
    logic [31:csr_arch_pkg::eentry_align]      eentry_q;
    logic [31:0]                               save_q [4];
    logic [31:0]                               tid;
    logic                                      commit;
    logic                                      wr_op;

    assign commit = cmd.run && !stall;
    assign wr_op = (cmd.op == csr_pipe_pkg::op_csrwr) || (cmd.op == csr_pipe_pkg::op_csrxchg);
    assign ticlr_wr = commit && wr_op && (cmd.num == csr_arch_pkg::csr_ticlr) && cmd.wdata[0];
    assign eentry = {eentry_q, {csr_arch_pkg::eentry_align{1'b0}}};

    always_comb
    begin
        case (num_rd)
            csr_arch_pkg::csr_crmd:   rdata_comb = {23'b0, crmd};
            csr_arch_pkg::csr_prmd:   rdata_comb = {29'b0, prmd};
            csr_arch_pkg::csr_ecfg:   rdata_comb = {19'b0, lie};
            csr_arch_pkg::csr_estat:
                rdata_comb = {1'b0, esubcode_q, ecode_q, 3'b0,
                              hw_int[8], ti, 1'b0, hw_int[7:0], is_bits};
            csr_arch_pkg::csr_era:    rdata_comb = era;
            csr_arch_pkg::csr_badv:   rdata_comb = badv;
            csr_arch_pkg::csr_eentry: rdata_comb = eentry;
            csr_arch_pkg::csr_save0:  rdata_comb = save_q[0];
            csr_arch_pkg::csr_save1:  rdata_comb = save_q[1];
            csr_arch_pkg::csr_save2:  rdata_comb = save_q[2];
            csr_arch_pkg::csr_save3:  rdata_comb = save_q[3];
            csr_arch_pkg::csr_tid:    rdata_comb = tid;
            csr_arch_pkg::csr_tcfg:   rdata_comb = 32'(tcfg);
            csr_arch_pkg::csr_tval:   rdata_comb = 32'(tval);
            default:                  rdata_comb = '0;   // ticlr reads zero
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd <= csr_arch_pkg::crmd_rst;
            prmd <= '0;
            lie <= '0;
            is_bits <= '0;
            ecode_q <= csr_arch_pkg::ecode_int;
            esubcode_q <= '0;
            era <= '0;
            badv <= '0;
            eentry_q <= '0;
            for (int i = 0; i < 4; i++)
                save_q[i] <= '0;
            tid <= '0;
            tcfg <= '0;
            tcfg_wr <= 1'b0;
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
        end
        else
        begin
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
            tcfg_wr <= 1'b0;
            if (commit)
            begin
                case (cmd.op)
                    csr_pipe_pkg::op_trap:
                    begin
                        prmd.pplv <= crmd.plv;
                        prmd.pie <= crmd.ie;
                        crmd.plv <= 2'b00;
                        crmd.ie <= 1'b0;
                        era <= cmd.pc;
                        ecode_q <= cmd.ecode;
                        esubcode_q <= cmd.esubcode;
                        if (cmd.ecode == csr_arch_pkg::ecode_ale
                            || cmd.ecode == csr_arch_pkg::ecode_ade)
                            badv <= cmd.badv;
                        excp_flush <= 1'b1;
                    end
                    csr_pipe_pkg::op_ertn:
                    begin
                        crmd.plv <= prmd.pplv;
                        crmd.ie <= prmd.pie;
                        ertn_flush <= 1'b1;
                    end
                    csr_pipe_pkg::op_csrwr, csr_pipe_pkg::op_csrxchg:
                    begin
                        case (cmd.num)
                            csr_arch_pkg::csr_crmd:   crmd <= csr_arch_pkg::crmd_t'(cmd.wdata[8:0]);
                            csr_arch_pkg::csr_prmd:   prmd <= csr_arch_pkg::prmd_t'(cmd.wdata[2:0]);
                            csr_arch_pkg::csr_ecfg:   lie <= cmd.wdata[12:0] & csr_arch_pkg::lie_mask;
                            csr_arch_pkg::csr_estat:  is_bits <= cmd.wdata[1:0];  // sw irq only
                            csr_arch_pkg::csr_era:    era <= cmd.wdata;
                            csr_arch_pkg::csr_badv:   badv <= cmd.wdata;
                            csr_arch_pkg::csr_eentry:
                                eentry_q <= cmd.wdata[31:csr_arch_pkg::eentry_align];
                            csr_arch_pkg::csr_save0,
                            csr_arch_pkg::csr_save1,
                            csr_arch_pkg::csr_save2,
                            csr_arch_pkg::csr_save3:  save_q[cmd.num[1:0]] <= cmd.wdata;
                            csr_arch_pkg::csr_tid:    tid <= cmd.wdata;
                            csr_arch_pkg::csr_tcfg:
                            begin
                                tcfg <= cmd.wdata[csr_arch_pkg::timer_w-1:0];
                                tcfg_wr <= 1'b1;   // timer reloads next cycle
                            end
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/csr_timer.sv
`default_nettype none

module csr_timer (
    input  wire logic                               clk,
    input  wire logic                               rstn,
    input  wire logic                               tcfg_wr,
    input  wire logic [csr_arch_pkg::timer_w-1:0]   tcfg,
    input  wire logic                               ticlr_wr,
    output logic [csr_arch_pkg::timer_w-1:0]        tval,
    output logic                                    ti
);

    logic                              en;
    logic                              periodic;
    logic [csr_arch_pkg::timer_w-1:0]  reload;

    assign en = tcfg[0];
    assign periodic = tcfg[1];
    assign reload = {tcfg[csr_arch_pkg::timer_w-1:2], 2'b00};

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval <= '0;
            ti <= 1'b0;
        end
        else
        begin
            if (ticlr_wr)
                ti <= 1'b0;
            else if (en && !tcfg_wr && tval == '0)
                ti <= 1'b1;

            if (tcfg_wr)
                tval <= reload;
            else if (en)
            begin
                if (tval == '0 && periodic)
                    tval <= reload;
                else if (tval != '1)    // one-shot parks at all ones
                    tval <= tval - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/csr_unit.sv
`default_nettype none

module csr_unit (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   stall,
    input  wire logic                   flush,
    input  wire csr_pipe_pkg::csr_req_t req,
    input  wire logic [8:0]             hw_int,     // 8 hw lines, ipi on top
    output csr_pipe_pkg::csr_resp_t     resp,
    output logic                        excp_flush,
    output logic                        ertn_flush,
    output csr_arch_pkg::crmd_t         crmd
);

    csr_arch_pkg::csr_num_t             num_rd;
    csr_pipe_pkg::csr_cmd_t             cmd;
    logic [csr_arch_pkg::irq_w-1:0]     lie;
    logic [1:0]                         is_bits;
    logic [31:0]                        era;
    logic [31:0]                        eentry;
    logic [31:0]                        rdata_comb;
    logic                               ti;
    logic                               tcfg_wr;
    logic [csr_arch_pkg::timer_w-1:0]   tcfg;
    logic                               ticlr_wr;
    logic [csr_arch_pkg::timer_w-1:0]   tval;

    csr_decode u_decode (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .flush      (flush),
        .req        (req),
        .ti         (ti),
        .hw_int     (hw_int),
        .crmd       (crmd),
        .lie        (lie),
        .is_bits    (is_bits),
        .era        (era),
        .eentry     (eentry),
        .rdata_comb (rdata_comb),
        .num_rd     (num_rd),
        .cmd        (cmd),
        .resp       (resp)
    );

    csr_regfile u_regfile (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .cmd        (cmd),
        .num_rd     (num_rd),
        .ti         (ti),
        .hw_int     (hw_int),
        .tval       (tval),
        .rdata_comb (rdata_comb),
        .crmd       (crmd),
        .lie        (lie),
        .is_bits    (is_bits),
        .era        (era),
        .eentry     (eentry),
        .tcfg_wr    (tcfg_wr),
        .tcfg       (tcfg),
        .ticlr_wr   (ticlr_wr),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush)
    );

    csr_timer u_timer (
        .clk        (clk),
        .rstn       (rstn),
        .tcfg_wr    (tcfg_wr),
        .tcfg       (tcfg),
        .ticlr_wr   (ticlr_wr),
        .tval       (tval),
        .ti         (ti)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the csr_unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_csr_unit -f list.f -o tb_csr_unit

./obj_dir/tb_csr_unit | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: sim/csr_patterns.txt
// op num wdata mask excp ecode pc badv exp_rdata exp_flush exp_redirect wait
// op 1 csrrd 2 csrwr 3 csrxchg 4 ertn 5 trap 6 crmd check 7 ti poll ff end
2 030 00000000 00000000 0 00 1c000000 00000000 00000000 1 1c000004 0
2 031 00000000 00000000 0 00 1c000004 00000000 00000000 1 1c000008 0
2 032 00000000 00000000 0 00 1c000008 00000000 00000000 1 1c00000c 0
2 033 00000000 00000000 0 00 1c00000c 00000000 00000000 1 1c000010 0
2 006 1c001234 00000000 0 00 1c000010 00000000 00000000 1 1c000014 0
2 00c 1c008abc 00000000 0 00 1c000014 00000000 00000000 1 1c000018 1
1 030 00000000 00000000 0 00 1c000018 00000000 00000000 0 1c00001c 0
1 033 00000000 00000000 0 00 1c00001c 00000000 00000000 0 1c000020 0
1 006 00000000 00000000 0 00 1c000020 00000000 1c001234 0 1c000024 0
1 00c 00000000 00000000 0 00 1c000024 00000000 1c008a80 0 1c000028 0
3 031 00000000 0000ffff 0 00 1c000028 00000000 00000000 1 1c00002c 0
1 031 00000000 00000000 0 00 1c00002c 00000000 00000000 0 1c000030 0
2 000 0000000f 00000000 0 00 1c000030 00000000 00000008 1 1c000034 0
6 000 0000000f 00000000 0 00 00000000 00000000 00000000 0 00000000 0
5 000 00000000 00000000 1 09 1c000400 00001003 0000000f 1 1c008a80 1
6 000 00000008 00000000 0 00 00000000 00000000 00000000 0 00000000 0
1 001 00000000 00000000 0 00 1c008a80 00000000 00000007 0 1c008a84 0
1 006 00000000 00000000 0 00 1c008a84 00000000 1c000400 0 1c008a88 0
1 007 00000000 00000000 0 00 1c008a88 00000000 00001003 0 1c008a8c 0
1 005 00000000 00000000 0 00 1c008a8c 00000000 00090000 0 1c008a90 0
4 001 00000000 00000000 0 00 1c008a90 00000000 00000007 1 1c000400 0
6 000 0000000f 00000000 0 00 00000000 00000000 00000000 0 00000000 0
2 004 00000800 00000000 0 00 1c000404 00000000 00000000 1 1c000408 0
2 000 00000008 00000000 0 00 1c000408 00000000 0000000f 1 1c00040c 0
2 041 00000011 00000000 0 00 1c00040c 00000000 00000000 1 1c000410 0
7 005 00000000 00000000 0 00 1c000410 00000000 00090000 0 1c000414 0
2 000 0000000c 00000000 0 00 1c000414 00000000 00000008 1 1c000418 0
1 005 00000000 00000000 0 00 1c000418 00000000 00090800 1 1c008a80 0
1 005 00000000 00000000 0 00 1c008a80 00000000 00000800 0 1c008a84 0
6 000 00000008 00000000 0 00 00000000 00000000 00000000 0 00000000 0
2 044 00000001 00000000 0 00 1c008a84 00000000 00000000 1 1c008a88 0
1 005 00000000 00000000 0 00 1c008a88 00000000 00000000 0 1c008a8c 0
ff 000 00000000 00000000 0 00 00000000 00000000 00000000 0 00000000 0

// File: sim/csr_unit_assert.sv
`default_nettype none

module csr_unit_assert (
    input wire logic clk,
    input wire logic rstn,
    input wire logic excp_flush,
    input wire logic ertn_flush
);

    // trap and return never commit in the same cycle
    flush_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush))
        else $error("excp_flush and ertn_flush high together");

    excp_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        excp_flush |=> !excp_flush)
        else $error("excp_flush high for more than one cycle");

    ertn_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        ertn_flush |=> !ertn_flush)
        else $error("ertn_flush high for more than one cycle");

    quiet_in_reset: assert property (@(posedge clk)
        !rstn |=> !excp_flush && !ertn_flush)
        else $error("flush pulse while in reset");

endmodule

bind csr_unit csr_unit_assert u_assert (
    .clk        (clk),
    .rstn       (rstn),
    .excp_flush (excp_flush),
    .ertn_flush (ertn_flush)
);

`default_nettype wire

// File: sim/tb_csr_unit.sv
`default_nettype none

module tb_csr_unit;

    // one line of the pattern file with the first column at the top
    typedef struct packed {
        logic [31:0] op;
        logic [31:0] num;
        logic [31:0] wdata;
        logic [31:0] mask;
        logic [31:0] excp;
        logic [31:0] ecode;
        logic [31:0] pc;
        logic [31:0] badv;
        logic [31:0] rdata;
        logic [31:0] flush;
        logic [31:0] redirect;
        logic [31:0] wait_n;
    } pattern_t;

    localparam int max_lines = 64;
    localparam int poll_bound = 64;

    logic                       clk;
    logic                       rstn;
    logic                       stall;
    logic                       flush;
    csr_pipe_pkg::csr_req_t     req;
    logic [8:0]                 hw_int;
    csr_pipe_pkg::csr_resp_t    resp;
    logic                       excp_flush;
    logic                       ertn_flush;
    csr_arch_pkg::crmd_t        crmd;

    logic [31:0] pat_mem [max_lines*12];
    logic [31:0] save_model [4];    // SAVE contents follow the random writes
    int          n_lines;
    int          limit;
    int          cycles;
    int          checks;

    csr_unit uut (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .flush      (flush),
        .req        (req),
        .hw_int     (hw_int),
        .resp       (resp),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .crmd       (crmd)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > limit)
            stop_run($sformatf("cycle limit of %0d reached before the tests finished", limit));
    end

    task automatic check_resp(input csr_pipe_pkg::csr_resp_t got,
                              input csr_pipe_pkg::csr_resp_t exp, input string what);
        checks++;
        if (got !== exp)
            stop_run($sformatf("FAIL at %0t: %s flush/pc/rdata %b/%h/%h expected %b/%h/%h",
                               $time, what, got.flush, got.redirect_pc, got.rdata,
                               exp.flush, exp.redirect_pc, exp.rdata));
    endtask

    task automatic check_crmd(input csr_arch_pkg::crmd_t got,
                              input csr_arch_pkg::crmd_t exp, input string what);
        checks++;
        if (got !== exp)
            stop_run($sformatf("FAIL at %0t: %s crmd %h expected %h", $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp)
            stop_run($sformatf("FAIL at %0t: %s is %b expected %b", $time, what, got, exp));
    endtask

    function automatic pattern_t get_pattern(input int idx);
        pattern_t p;
        for (int k = 0; k < 12; k++)
            p[32*(11-k) +: 32] = pat_mem[idx*12 + k];
        return p;
    endfunction

    // called on a falling edge, returns on the falling edge after commit
    task automatic issue(input csr_pipe_pkg::csr_req_t r, output csr_pipe_pkg::csr_resp_t got,
                         output logic got_excp, output logic got_ertn);
        req = r;
        @(posedge clk);
        @(negedge clk);
        req = '0;
        got = resp;
        @(posedge clk);
        @(negedge clk);
        got_excp = excp_flush;
        got_ertn = ertn_flush;
    endtask

    task automatic run_line(input int idx, input pattern_t p);
        csr_pipe_pkg::csr_req_t  r;
        csr_pipe_pkg::csr_resp_t exp;
        csr_pipe_pkg::csr_resp_t got;
        logic                    got_excp;
        logic                    got_ertn;
        logic                    seen;
        logic [1:0]              slot;
        r = '0;
        r.valid = 1'b1;
        r.op = csr_pipe_pkg::csr_op_e'(p.op[2:0]);
        r.num = p.num[13:0];
        r.wdata = p.wdata;
        r.mask = p.mask;
        r.pc = p.pc;
        r.excp = p.excp[0];
        r.ecode = csr_arch_pkg::ecode_e'(p.ecode[5:0]);
        r.badv = p.badv;
        exp.flush = p.flush[0];
        exp.redirect_pc = p.redirect;
        exp.rdata = p.rdata;
        slot = r.num[1:0];
        if (p.op == 6)
            check_crmd(crmd, csr_arch_pkg::crmd_t'(p.wdata[8:0]), $sformatf("line %0d", idx));
        else if (p.op == 7)
        begin
            r.op = csr_pipe_pkg::op_csrrd;
            seen = 1'b0;
            for (int n = 0; n < poll_bound && !seen; n++)
            begin
                issue(r, got, got_excp, got_ertn);
                seen = got.rdata[11];
                got.rdata[11] = 1'b0;   // ti is the polled bit
                check_resp(got, exp, $sformatf("line %0d poll", idx));
                check_flag(got_excp, 1'b0, "excp_flush during poll");
            end
            if (!seen)
                stop_run("timer interrupt did not show in ESTAT within the poll bound");
        end
        else
        begin
            if (r.num >= csr_arch_pkg::csr_save0 && r.num <= csr_arch_pkg::csr_save3)
            begin
                exp.rdata = save_model[slot];
                if (r.op == csr_pipe_pkg::op_csrwr || r.op == csr_pipe_pkg::op_csrxchg)
                begin
                    r.wdata = $urandom;
                    if (r.op == csr_pipe_pkg::op_csrxchg)
                        save_model[slot] = (exp.rdata & ~r.mask) | (r.wdata & r.mask);
                    else
                        save_model[slot] = r.wdata;
                end
            end
            issue(r, got, got_excp, got_ertn);
            check_resp(got, exp, $sformatf("line %0d", idx));
            check_flag(got_excp, p.op == 5 || (p.op == 1 && p.flush[0]), "excp_flush");
            check_flag(got_ertn, p.op == 4, "ertn_flush");
        end
        repeat (p.wait_n) @(negedge clk);
    endtask

    initial
    begin
        pattern_t    p;
        rstn = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        req = '0;
        hw_int = '0;
        cycles = 0;
        checks = 0;
        void'($urandom(32'h63a8_b1e9));
        for (int i = 0; i < 4; i++)
            save_model[i] = '0;
        $readmemh("sim/csr_patterns.txt", pat_mem);

        // limit grows with every line up to the end marker
        n_lines = 0;
        limit = 16 + poll_bound * 4;
        p = get_pattern(0);
        while (p.op != 32'h0000_00ff)
        begin
            limit += int'(p.wait_n) + 4;
            n_lines++;
            if (n_lines == max_lines)
                stop_run("pattern file has no end marker");
            p = get_pattern(n_lines);
        end

        repeat (8) @(negedge clk);
        rstn = 1'b1;
        check_flag(resp.flush, 1'b0, "resp.flush after reset");
        check_flag(excp_flush, 1'b0, "excp_flush after reset");
        check_flag(ertn_flush, 1'b0, "ertn_flush after reset");
        check_crmd(crmd, csr_arch_pkg::crmd_t'(9'h008), "after reset");

        for (int i = 0; i < n_lines; i++)
            run_line(i, get_pattern(i));

        if (checks == 0)
            stop_run("no checks were run");
        else
        begin
            $display("All tests passed!");
            $finish;
        end
    end

endmodule

`default_nettype wire
